//--- tinker_core.f
+incdir+.
tinker_pkg.sv
tinker_regfile.sv
tinker_alu.sv
tinker_branch.sv
tinker_lsu.sv
tinker_fetch.sv
tinker_control.sv
tinker_core.sv
tinker_chk.sv
tinker_tb.sv

//--- run.sh
#!/bin/sh
# Build the Tinker core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tinker_core.f \
    --top-module tinker_tb -o tinker_sim \
    && ./obj_dir/tinker_sim | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tinker_tb.sv
// Tinker core testbench with byte memory model and directed program tests
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_tb import tinker_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [63:0] mem_addr;
    logic        mem_rd;
    logic        mem_wr;
    logic [63:0] mem_wdata;
    logic [63:0] mem_rdata;
    logic        hlt;

    logic [7:0]  mem [logic [63:0]];        // Sparse byte memory
    logic [63:0] wr_q [$];                  // Store addresses seen
    logic [63:0] rd_q [$];                  // Data read addresses seen
    int          mem_gen;                   // Bumped on every memory change
    int          errors;
    int          checks;
    logic [31:0] rng;
    logic [63:0] asm_pc;                    // Next assembly address

    tinker_core dut0 (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .hlt       (hlt)
    );

    always #4 clk = ~clk;                   // 8 ns period

    // ------------------------------
    // Memory model
    // ------------------------------
    function automatic logic [63:0] read_word(input logic [63:0] a);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            if (mem.exists(a + 64'(i))) w[8*i +: 8] = mem[a + 64'(i)];  // Little-endian
        end
        return w;
    endfunction

    always @(mem_addr or mem_gen) mem_rdata = read_word(mem_addr);  // Same-cycle read

    always @(posedge clk) begin
        if (mem_wr) begin
            for (int i = 0; i < 8; i++) mem[mem_addr + 64'(i)] = mem_wdata[8*i +: 8];
            wr_q.push_back(mem_addr);
            mem_gen++;
        end
        if (mem_rd && mem_addr >= 64'h4000) rd_q.push_back(mem_addr);  // Data region only
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [11:0] next_lit();
        rng = xorshift(rng);
        return rng[11:0];
    endfunction

    function automatic logic [63:0] sext(input logic [11:0] l);
        return {{52{l[11]}}, l};
    endfunction

    function automatic logic [31:0] enc_r(input tk_opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {op, rd, rs, rt, 12'h000};
    endfunction

    function automatic logic [31:0] enc_l(input tk_opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [11:0] lit);
        return {op, rd, rs, 5'd0, lit};
    endfunction

    task automatic emit(input logic [31:0] w);
        for (int i = 0; i < 4; i++) mem[asm_pc + 64'(i)] = w[8*i +: 8];
        asm_pc = asm_pc + 64'd4;
    endtask

    task automatic put_word(input logic [63:0] a, input logic [63:0] d);
        for (int i = 0; i < 8; i++) mem[a + 64'(i)] = d[8*i +: 8];
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // Load address 0x8000 into r30
    task automatic emit_base();
        emit(enc_l(OP_MOV_L, 5'd30, 5'd0, 12'd1));
        emit(enc_l(OP_SHLI, 5'd30, 5'd30, 12'd15));
    endtask

    task automatic start_program();
        @(posedge clk);
        reset <= 1'b1;
        mem.delete();
        wr_q.delete();
        rd_q.delete();
        asm_pc = `TK_RESET_PC;
    endtask

    task automatic release_reset();
        mem_gen++;
        repeat (8) begin                    // Outputs quiet during reset
            @(negedge clk);
            check("hlt", 64'(hlt), 64'd0);
            check("mem_wr", 64'(mem_wr), 64'd0);
            check("mem_rd", 64'(mem_rd), 64'd0);
        end
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_fetch();
        int n;
        n = 0;
        while (!mem_rd && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!mem_rd) begin
            errors++;
            $display("timeout: no instruction fetch after reset");
        end
    endtask

    task automatic wait_halt(output int cycles);
        cycles = 0;
        while (!hlt && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (!hlt) begin
            errors++;
            $display("timeout: hlt never rose");
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset();
        int n;
        start_program();
        emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
        release_reset();
        wait_fetch();
        check("mem_addr", mem_addr, `TK_RESET_PC);  // First fetch address
        wait_halt(n);
        check("write_count", 64'(wr_q.size()), 64'd0);
    endtask

    task automatic test_alu();
        logic [11:0] l1, l2, l4, l5, l7;
        logic [11:0] s, sh;
        logic [63:0] a, b;
        logic [63:0] exp [13];
        int n;
        l1 = next_lit();
        l2 = next_lit();
        s  = next_lit() & 12'h01f;          // Register shift amount
        l4 = next_lit();
        l5 = next_lit();
        sh = next_lit() & 12'h03f;          // Literal shift amount
        l7 = next_lit();
        a  = sext(l1);
        b  = sext(l2);
        start_program();
        emit_base();
        emit(enc_l(OP_MOV_L, 5'd1, 5'd0, l1));
        emit(enc_l(OP_MOV_L, 5'd2, 5'd0, l2));
        emit(enc_l(OP_MOV_L, 5'd3, 5'd0, s));
        emit(enc_r(OP_ADD, 5'd4, 5'd1, 5'd2));
        exp[0]  = a + b;
        emit(enc_l(OP_ADDI, 5'd5, 5'd1, l4));
        exp[1]  = a + sext(l4);
        emit(enc_r(OP_SUB, 5'd6, 5'd1, 5'd2));
        exp[2]  = a - b;
        emit(enc_l(OP_SUBI, 5'd7, 5'd1, l5));
        exp[3]  = a - sext(l5);
        emit(enc_r(OP_AND, 5'd8, 5'd1, 5'd2));
        exp[4]  = a & b;
        emit(enc_r(OP_OR, 5'd9, 5'd1, 5'd2));
        exp[5]  = a | b;
        emit(enc_r(OP_XOR, 5'd10, 5'd1, 5'd2));
        exp[6]  = a ^ b;
        emit(enc_r(OP_NOT, 5'd11, 5'd1, 5'd0));
        exp[7]  = ~a;
        emit(enc_r(OP_SHR, 5'd12, 5'd1, 5'd3));
        exp[8]  = a >> s;
        emit(enc_r(OP_SHL, 5'd13, 5'd1, 5'd3));
        exp[9]  = a << s;
        emit(enc_l(OP_SHLI, 5'd14, 5'd1, sh));
        exp[10] = a << sh;
        emit(enc_r(OP_MOV_R, 5'd15, 5'd2, 5'd0));
        exp[11] = b;
        emit(enc_l(OP_MOV_L, 5'd16, 5'd0, l7));
        exp[12] = sext(l7);
        for (int k = 0; k < 13; k++) emit(enc_l(OP_STORE, 5'd30, 5'(4 + k), 12'(8 * k)));
        emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
        release_reset();
        wait_halt(n);
        for (int k = 0; k < 13; k++) check($sformatf("alu_r%0d", 4 + k),
                                           read_word(64'h8000 + 64'(8 * k)), exp[k]);
    endtask

    task automatic test_ldst();
        logic [63:0] data;
        int n;
        rng  = xorshift(rng);
        data[63:32] = rng;
        rng  = xorshift(rng);
        data[31:0] = rng;
        start_program();
        put_word(64'h8100, data);
        emit_base();
        emit(enc_l(OP_LOAD, 5'd1, 5'd30, 12'h100));   // rs+L = 0x8100
        emit(enc_l(OP_STORE, 5'd30, 5'd1, 12'd16));   // rd+L = 0x8010
        emit(enc_l(OP_ADDI, 5'd20, 5'd30, 12'd32));
        emit(enc_l(OP_LOAD, 5'd2, 5'd20, 12'hff0));   // 0x8020 - 16
        emit(enc_l(OP_STORE, 5'd20, 5'd2, 12'd8));    // 0x8028
        emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
        release_reset();
        wait_halt(n);
        check("store_count", 64'(wr_q.size()), 64'd2);
        check("load_count", 64'(rd_q.size()), 64'd2);
        if (wr_q.size() == 2) begin
            check("store_addr0", wr_q[0], 64'h8010);
            check("store_addr1", wr_q[1], 64'h8028);
        end
        if (rd_q.size() == 2) begin
            check("load_addr0", rd_q[0], 64'h8100);
            check("load_addr1", rd_q[1], 64'h8010);
        end
        check("mem_8010", read_word(64'h8010), data);
        check("mem_8028", read_word(64'h8028), data);
    endtask

    // r28 = address of the instruction two after the next one
    task automatic emit_abs_target();
        emit(enc_l(OP_ADDI, 5'd28, 5'd29, 12'(asm_pc + 64'd12 - `TK_RESET_PC)));
    endtask

    task automatic test_branch();
        logic [6:0] taken;
        int n;
        taken = 7'b111_0101;                // Bit k set when case k jumps
        start_program();
        emit_base();
        emit(enc_l(OP_MOV_L, 5'd29, 5'd0, 12'd1));
        emit(enc_l(OP_SHLI, 5'd29, 5'd29, 12'd13));   // r29 = 0x2000
        emit(enc_l(OP_MOV_L, 5'd1, 5'd0, 12'd5));
        emit(enc_l(OP_MOV_L, 5'd2, 5'd0, 12'd0));
        emit(enc_l(OP_MOV_L, 5'd3, 5'd0, 12'hffd));   // -3
        emit(enc_l(OP_MOV_L, 5'd4, 5'd0, 12'd8));
        for (int k = 0; k < 7; k++) begin
            emit(enc_l(OP_MOV_L, 5'd9, 5'd0, 12'(12'h100 + k)));  // Case marker
            case (k)
                0: begin
                    emit_abs_target();
                    emit(enc_r(OP_BRNZ, 5'd28, 5'd1, 5'd0));
                end
                1: begin
                    emit_abs_target();
                    emit(enc_r(OP_BRNZ, 5'd28, 5'd2, 5'd0));
                end
                2: begin
                    emit_abs_target();
                    emit(enc_r(OP_BRGT, 5'd28, 5'd1, 5'd3));
                end
                3: begin
                    emit_abs_target();
                    emit(enc_r(OP_BRGT, 5'd28, 5'd3, 5'd1));
                end
                4: emit(enc_r(OP_BRR_R, 5'd4, 5'd0, 5'd0));
                5: emit(enc_l(OP_BRR_L, 5'd0, 5'd0, 12'd8));
                default: begin
                    emit_abs_target();
                    emit(enc_r(OP_BR, 5'd28, 5'd0, 5'd0));
                end
            endcase
            emit(enc_l(OP_STORE, 5'd30, 5'd9, 12'(8 * k)));  // Skipped when taken
        end
        emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
        release_reset();
        wait_halt(n);
        for (int k = 0; k < 7; k++) check($sformatf("marker%0d", k),
                                          read_word(64'h8000 + 64'(8 * k)),
                                          taken[k] ? 64'd0 : 64'h100 + 64'(k));
        check("marker_count", 64'(wr_q.size()), 64'd2);
    endtask

    task automatic test_timing();
        int n;
        start_program();
        emit(enc_l(OP_MOV_L, 5'd1, 5'd0, 12'd5));
        emit(enc_l(OP_ADDI, 5'd2, 5'd1, 12'd3));
        emit(enc_r(OP_ADD, 5'd3, 5'd1, 5'd2));
        emit(enc_l(OP_STORE, 5'd0, 5'd3, 12'h100));   // r0 is zero after reset
        emit(enc_r(OP_HALT, 5'd0, 5'd0, 5'd0));
        release_reset();
        wait_fetch();
        wait_halt(n);
        check("halt_cycles", 64'(n), 64'(3 * 4 + 5 + 2));
        repeat (20) begin
            @(negedge clk);
            check("hlt_held", 64'(hlt), 64'd1);
        end
        check("write_count", 64'(wr_q.size()), 64'd1);
        check("mem_100", read_word(64'h100), 64'd13);
    endtask

    // ------------------------------
    // Sequence and report
    // ------------------------------
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        mem_rdata = '0;
        mem_gen   = 0;
        errors    = 0;
        checks    = 0;
        rng       = 32'h034a_cb13;
        asm_pc    = `TK_RESET_PC;
        test_reset();
        test_alu();
        test_ldst();
        test_branch();
        test_timing();
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tinker_chk.sv
// Tinker core protocol checker, concurrent assertions bound to the core ports
`timescale 1ns/1ps

module tinker_chk (
    input logic clk,
    input logic reset,
    input logic mem_rd,
    input logic mem_wr,
    input logic hlt
);

    // ------------------------------
    // Memory port
    // ------------------------------
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset) !(mem_rd && mem_wr)
    ) else $error("mem_rd and mem_wr high together");

    // ------------------------------
    // Halt behavior
    // ------------------------------
    a_hlt_sticky: assert property (
        @(posedge clk) disable iff (reset) hlt |=> hlt
    ) else $error("hlt dropped without reset");

    // No store may start once halted
    a_no_wr_halted: assert property (
        @(posedge clk) disable iff (reset) hlt |-> !mem_wr
    ) else $error("memory write while halted");

endmodule

bind tinker_core tinker_chk chk0 (
    .clk    (clk),
    .reset  (reset),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .hlt    (hlt)
);

//--- tinker_core.sv
// Tinker multicycle 64-bit core top level, control plus datapath units
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_core import tinker_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    output logic [`TK_XLEN-1:0] mem_addr,   // Byte address
    output logic               mem_rd,
    output logic               mem_wr,      // Write at rising edge
    output logic [`TK_XLEN-1:0] mem_wdata,
    input  logic [`TK_XLEN-1:0] mem_rdata,  // Same-cycle read data
    output logic               hlt
);

    // ------------------------------
    // Control enables
    // ------------------------------
    logic ir_write;
    logic pc_write;
    logic reg_write;
    logic wb_load;                          // Writeback from MDR
    logic alu_latch;
    logic mdr_latch;
    logic fetch_sel;                        // PC drives the address
    logic is_branch;

    // ------------------------------
    // Datapath
    // ------------------------------
    tk_opcode_e             opcode;
    logic [`TK_REG_AW-1:0]  rd;
    logic [`TK_REG_AW-1:0]  rs;
    logic [`TK_REG_AW-1:0]  rt;
    logic [`TK_XLEN-1:0]    imm;            // Sign-extended literal
    logic [`TK_XLEN-1:0]    pc;
    logic [`TK_XLEN-1:0]    next_pc;
    logic [`TK_XLEN-1:0]    rd_val;
    logic [`TK_XLEN-1:0]    rs_val;
    logic [`TK_XLEN-1:0]    rt_val;
    logic [`TK_XLEN-1:0]    alu_result;
    logic [`TK_XLEN-1:0]    load_data;

    tinker_control u_control (
        .clk       (clk),
        .reset     (reset),
        .opcode    (opcode),
        .is_branch (is_branch),
        .ir_write  (ir_write),
        .pc_write  (pc_write),
        .reg_write (reg_write),
        .wb_load   (wb_load),
        .alu_latch (alu_latch),
        .mdr_latch (mdr_latch),
        .fetch_sel (fetch_sel),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .hlt       (hlt)
    );

    tinker_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .ir_write  (ir_write),
        .pc_write  (pc_write),
        .next_pc   (next_pc),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .opcode    (opcode),
        .rd        (rd),
        .rs        (rs),
        .rt        (rt),
        .imm       (imm)
    );

    tinker_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .reg_write  (reg_write),
        .wb_load    (wb_load),
        .alu_result (alu_result),
        .load_data  (load_data),
        .rd         (rd),
        .rs         (rs),
        .rt         (rt),
        .rd_val     (rd_val),
        .rs_val     (rs_val),
        .rt_val     (rt_val)
    );

    tinker_alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .alu_latch  (alu_latch),
        .opcode     (opcode),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .imm        (imm),
        .alu_result (alu_result)
    );

    tinker_branch u_branch (
        .opcode    (opcode),
        .pc        (pc),
        .rd_val    (rd_val),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .imm       (imm),
        .next_pc   (next_pc),
        .is_branch (is_branch)
    );

    tinker_lsu u_lsu (
        .clk       (clk),
        .reset     (reset),
        .fetch_sel (fetch_sel),
        .mdr_latch (mdr_latch),
        .opcode    (opcode),
        .pc        (pc),
        .rd_val    (rd_val),
        .rs_val    (rs_val),
        .imm       (imm),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .load_data (load_data)
    );

endmodule

//--- tinker_control.sv
// Tinker control FSM, sequences each instruction and drives all enables
`timescale 1ns/1ps

module tinker_control import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  tk_opcode_e opcode,
    input  logic       is_branch,
    output logic       ir_write,
    output logic       pc_write,
    output logic       reg_write,
    output logic       wb_load,
    output logic       alu_latch,
    output logic       mdr_latch,
    output logic       fetch_sel,
    output logic       mem_rd,
    output logic       mem_wr,
    output logic       hlt
);

    tk_state_e state;
    tk_state_e state_next;
    logic      armed;                       // Set by first clock after reset
    logic      op_load;
    logic      op_store;
    logic      op_mem;
    logic      op_no_wb;

    // ------------------------------
    // Opcode classes
    // ------------------------------
    assign op_load  = (opcode == OP_LOAD);
    assign op_store = (opcode == OP_STORE);
    assign op_mem   = op_load | op_store;   // Needs S_MEMORY
    assign op_no_wb = op_store | is_branch | (opcode == OP_HALT);

    // Holds the FSM idle in S_FETCH for one edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            S_FETCH:     state_next = armed ? S_DECODE : S_FETCH;
            S_DECODE:    state_next = (opcode == OP_HALT) ? S_HALTED : S_EXECUTE;
            S_EXECUTE: begin
                if (op_mem) begin
                    state_next = S_MEMORY;
                end else if (is_branch) begin
                    state_next = S_FETCH;   // PC already written
                end else begin
                    state_next = S_WRITEBACK;
                end
            end
            S_MEMORY:    state_next = S_WRITEBACK;
            S_WRITEBACK: state_next = S_FETCH;
            S_HALTED:    state_next = S_HALTED;  // Only reset leaves
            default:     state_next = S_FETCH;
        endcase
    end

    // ------------------------------
    // Per-state enables
    // ------------------------------
    always_comb begin
        ir_write  = 1'b0;
        pc_write  = 1'b0;
        reg_write = 1'b0;
        wb_load   = 1'b0;
        alu_latch = 1'b0;
        mdr_latch = 1'b0;
        fetch_sel = 1'b0;
        mem_rd    = 1'b0;
        mem_wr    = 1'b0;
        hlt       = 1'b0;
        case (state)
            S_FETCH: begin
                ir_write  = armed;          // IR loads at end of fetch
                mem_rd    = armed;
                fetch_sel = armed;
            end
            S_EXECUTE: begin
                alu_latch = 1'b1;
                pc_write  = is_branch;      // Taken or pc+4
            end
            S_MEMORY: begin
                mem_rd    = op_load;
                mdr_latch = op_load;
                mem_wr    = op_store;
            end
            S_WRITEBACK: begin
                reg_write = ~op_no_wb;
                wb_load   = op_load;
                pc_write  = 1'b1;           // Sequential advance
            end
            S_HALTED:    hlt = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

//--- tinker_fetch.sv
// Tinker fetch unit, holds PC and instruction register and splits fields
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_fetch import tinker_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ir_write,
    input  logic                  pc_write,
    input  logic [`TK_XLEN-1:0]   next_pc,
    input  logic [`TK_XLEN-1:0]   mem_rdata,
    output logic [`TK_XLEN-1:0]   pc,
    output tk_opcode_e            opcode,
    output logic [`TK_REG_AW-1:0] rd,
    output logic [`TK_REG_AW-1:0] rs,
    output logic [`TK_REG_AW-1:0] rt,
    output logic [`TK_XLEN-1:0]   imm
);

    tk_insn_u ir;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `TK_RESET_PC;
            ir <= '0;
        end else begin
            if (pc_write) pc <= next_pc;
            if (ir_write) ir <= tk_insn_u'(mem_rdata[`TK_INSN_W-1:0]);  // Low word
        end
    end

    // ------------------------------
    // Field decode
    // ------------------------------
    assign opcode = ir.r.opcode;
    assign rd     = ir.r.rd;
    assign rs     = ir.r.rs;
    assign rt     = ir.r.rt;                // Meaningless in literal forms
    assign imm    = {{(`TK_XLEN-`TK_IMM_W){ir.l.lit[`TK_IMM_W-1]}}, ir.l.lit};

endmodule

//--- tinker_lsu.sv
// Tinker load/store unit, address and store data plus memory data register
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_lsu import tinker_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetch_sel,
    input  logic                mdr_latch,
    input  tk_opcode_e          opcode,
    input  logic [`TK_XLEN-1:0] pc,
    input  logic [`TK_XLEN-1:0] rd_val,
    input  logic [`TK_XLEN-1:0] rs_val,
    input  logic [`TK_XLEN-1:0] imm,
    input  logic [`TK_XLEN-1:0] mem_rdata,
    output logic [`TK_XLEN-1:0] mem_addr,
    output logic [`TK_XLEN-1:0] mem_wdata,
    output logic [`TK_XLEN-1:0] load_data
);

    logic [`TK_XLEN-1:0] base;
    logic [`TK_XLEN-1:0] data_addr;

    // ------------------------------
    // Address path
    // ------------------------------
    assign base      = (opcode == OP_STORE) ? rd_val : rs_val;  // Store uses rd
    assign data_addr = base + imm;
    assign mem_addr  = fetch_sel ? pc : data_addr;              // Instruction fetch
    assign mem_wdata = rs_val;

    // Memory data register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_data <= '0;
        end else if (mdr_latch) begin
            load_data <= mem_rdata;         // End of S_MEMORY
        end
    end

endmodule

//--- tinker_branch.sv
// Tinker branch unit, evaluates conditions and produces the next PC
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_branch import tinker_pkg::*; (
    input  tk_opcode_e          opcode,
    input  logic [`TK_XLEN-1:0] pc,
    input  logic [`TK_XLEN-1:0] rd_val,
    input  logic [`TK_XLEN-1:0] rs_val,
    input  logic [`TK_XLEN-1:0] rt_val,
    input  logic [`TK_XLEN-1:0] imm,
    output logic [`TK_XLEN-1:0] next_pc,
    output logic                is_branch
);

    logic [`TK_XLEN-1:0] seq_pc;
    logic [`TK_XLEN-1:0] target;
    logic                taken;

    assign seq_pc = pc + `TK_PC_STEP;

    // ------------------------------
    // Target and condition
    // ------------------------------
    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b1;
        target    = rd_val;                 // Absolute forms
        case (opcode)
            OP_BR:    target = rd_val;
            OP_BRR_R: target = pc + rd_val;
            OP_BRR_L: target = pc + imm;
            OP_BRNZ:  taken  = (rs_val != '0);
            OP_BRGT:  taken  = ($signed(rs_val) > $signed(rt_val));
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    // Not taken falls through to pc+4
    assign next_pc = taken ? target : seq_pc;

endmodule

//--- tinker_alu.sv
// Tinker ALU, operand select, integer operations and result register
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_alu import tinker_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                alu_latch,
    input  tk_opcode_e          opcode,
    input  logic [`TK_XLEN-1:0] rs_val,
    input  logic [`TK_XLEN-1:0] rt_val,
    input  logic [`TK_XLEN-1:0] imm,
    output logic [`TK_XLEN-1:0] alu_result
);

    logic [`TK_XLEN-1:0] op_b;
    logic [`TK_XLEN-1:0] result;

    // ------------------------------
    // Second operand
    // ------------------------------
    always_comb begin
        case (opcode)
            OP_ADDI, OP_SUBI, OP_SHLI, OP_MOV_L,
            OP_LOAD, OP_STORE, OP_BRR_L: op_b = imm;  // Literal forms
            default:                     op_b = rt_val;
        endcase
    end

    // ------------------------------
    // Operations
    // ------------------------------
    always_comb begin
        case (opcode)
            OP_ADD, OP_ADDI: result = rs_val + op_b;
            OP_SUB, OP_SUBI: result = rs_val - op_b;
            OP_AND:          result = rs_val & op_b;
            OP_OR:           result = rs_val | op_b;
            OP_XOR:          result = rs_val ^ op_b;
            OP_NOT:          result = ~rs_val;
            OP_SHR:          result = rs_val >> op_b;   // Zero fill
            OP_SHL, OP_SHLI: result = rs_val << op_b;
            OP_MOV_R:        result = rs_val;
            OP_MOV_L:        result = op_b;             // Sign-extended L
            default:         result = '0;               // No ALU writeback
        endcase
    end

    // Result held from execute to writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_result <= '0;
        end else if (alu_latch) begin
            alu_result <= result;
        end
    end

endmodule

//--- tinker_regfile.sv
// Tinker register file, 32 x 64 bits with three read ports and one write
`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_write,
    input  logic                  wb_load,
    input  logic [`TK_XLEN-1:0]   alu_result,
    input  logic [`TK_XLEN-1:0]   load_data,
    input  logic [`TK_REG_AW-1:0] rd,
    input  logic [`TK_REG_AW-1:0] rs,
    input  logic [`TK_REG_AW-1:0] rt,
    output logic [`TK_XLEN-1:0]   rd_val,
    output logic [`TK_XLEN-1:0]   rs_val,
    output logic [`TK_XLEN-1:0]   rt_val
);

    logic [`TK_XLEN-1:0] regs [`TK_NREGS];  // r0 is an ordinary register
    logic [`TK_XLEN-1:0] wdata;

    assign wdata = wb_load ? load_data : alu_result;  // Writeback source

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TK_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[rd] <= wdata;              // End of S_WRITEBACK
        end
    end

    // Combinational reads
    assign rd_val = regs[rd];
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

endmodule

//--- tinker_pkg.sv
// Tinker core shared types for opcodes, FSM states and instruction word
`include "tinker_defines.svh"

package tinker_pkg;

    // ------------------------------
    // Opcodes
    // ------------------------------
    typedef enum logic [4:0] {
        OP_AND   = 5'b00000,                // rd = rs & rt
        OP_OR    = 5'b00001,
        OP_XOR   = 5'b00010,
        OP_NOT   = 5'b00011,                // rd = ~rs
        OP_SHR   = 5'b00100,                // Logical right
        OP_SHL   = 5'b00110,
        OP_SHLI  = 5'b00111,
        OP_BR    = 5'b01000,                // Absolute jump to rd
        OP_BRR_R = 5'b01001,                // pc + rd
        OP_BRR_L = 5'b01010,                // pc + L
        OP_BRNZ  = 5'b01011,
        OP_BRGT  = 5'b01110,                // Signed compare
        OP_LOAD  = 5'b10000,                // rd = mem[rs + L]
        OP_MOV_R = 5'b10001,
        OP_MOV_L = 5'b10010,
        OP_STORE = 5'b10011,                // mem[rd + L] = rs
        OP_ADD   = 5'b11000,
        OP_ADDI  = 5'b11001,
        OP_SUB   = 5'b11010,
        OP_SUBI  = 5'b11011,
        OP_HALT  = 5'b11111
    } tk_opcode_e;

    // ------------------------------
    // Control FSM states
    // ------------------------------
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALTED                            // Sticky until reset
    } tk_state_e;

    // ------------------------------
    // Instruction word
    // ------------------------------
    typedef struct packed {
        tk_opcode_e             opcode;
        logic [`TK_REG_AW-1:0]  rd;
        logic [`TK_REG_AW-1:0]  rs;
        logic [`TK_REG_AW-1:0]  rt;
        logic [`TK_IMM_W-1:0]   unused;     // Ignored in register form
    } tk_insn_reg_t;

    typedef struct packed {
        tk_opcode_e             opcode;
        logic [`TK_REG_AW-1:0]  rd;
        logic [`TK_REG_AW-1:0]  rs;
        logic [`TK_REG_AW-1:0]  unused;     // rt slot, ignored
        logic [`TK_IMM_W-1:0]   lit;        // Signed literal
    } tk_insn_lit_t;

    // Same 32 bits, two decodings
    typedef union packed {
        tk_insn_reg_t r;
        tk_insn_lit_t l;
    } tk_insn_u;

endpackage

//--- tinker_defines.svh
// Tinker core architectural widths and constants
`ifndef TINKER_DEFINES_SVH
`define TINKER_DEFINES_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define TK_XLEN     64                      // Data and address width
`define TK_INSN_W   32                      // Instruction word width
`define TK_REG_AW   5                       // Register index width
`define TK_NREGS    32                      // Architectural registers
`define TK_IMM_W    12                      // Raw literal width

// ------------------------------
// Program counter
// ------------------------------
`define TK_RESET_PC 64'h0000_0000_0000_2000 // First fetch address
`define TK_PC_STEP  64'd4                   // Sequential advance

`endif
